// ==== src/sdmac_pkg.sv ====
package sdmac_pkg;

    // CPU and peripheral bus widths
    localparam int DATA_W = 32;
    localparam int PORT_W = 16;

    // Register widths narrower than the CPU bus
    localparam int DAWR_W  = 4;
    localparam int CONTR_W = 8;
    localparam int ISTR_W  = 8;

    // CONTR bit positions
    localparam int CONTR_INTEN = 2;                  // Interrupt enable

    // ISTR bit positions
    localparam int ISTR_INTB  = 2;                   // Spare interrupt level
    localparam int ISTR_INTA  = 3;                   // SCSI chip interrupt level
    localparam int ISTR_INT_P = 4;                   // Either interrupt pending

    // Minimum ior_n / iow_n low time in sclk cycles
    localparam int STROBE_CYCLES = 3;
    localparam int STROBE_CNT_W  = $clog2(STROBE_CYCLES + 1);

    // Peripheral windows on addr[6:4]
    localparam logic [2:0] PORT_BASE_CSS  = 3'b100;  // SCSI chip
    localparam logic [2:0] PORT_BASE_CSX0 = 3'b101;  // Port 1A and 1B
    localparam logic [2:0] PORT_BASE_CSX1 = 3'b110;  // Port 2

    // Register word addresses, byte offset divided by four
    typedef enum logic [4:0] {
        REG_DAWR  = 5'h00,                           // Offset 0x00
        REG_WTC   = 5'h01,                           // Offset 0x04
        REG_CONTR = 5'h02,                           // Offset 0x08
        REG_ACR   = 5'h03,                           // Offset 0x0C
        REG_ISTR  = 5'h07                            // Offset 0x1C, read only
    } reg_addr_e;

    // Peripheral port sequencer states
    typedef enum logic [2:0] {
        PS_IDLE,                                     // Waiting for a port access
        PS_STROBE,                                   // Minimum strobe width
        PS_WAIT,                                     // Held off by iordy
        PS_ACK,                                      // dsack_n pulse
        PS_DONE                                      // Waiting for ds_n to rise
    } port_state_e;

endpackage

// ==== src/addr_decoder.sv ====
module addr_decoder (
    input  logic [6:2] addr,
    input  logic       a12,
    input  logic       cs_n,
    input  logic       as_n,
    output logic       reg_sel,
    output logic       css_n,
    output logic       csx0_n,
    output logic       csx1_n
);
    import sdmac_pkg::*;

    logic       access;                              // Chip select qualified by as_n
    logic       port_ok;                             // Port space not claimed by IDE
    logic [2:0] win;                                 // Upper address bits

    assign access  = !cs_n && !as_n;
    assign port_ok = access && !a12;                 // a12 high belongs to the IDE card
    assign win     = addr[6:4];

    // Everything below the first port window is register space
    assign reg_sel = access && (win < PORT_BASE_CSS);

    // Peripheral chip selects, active low
    assign css_n  = !(port_ok && (win == PORT_BASE_CSS));
    assign csx0_n = !(port_ok && (win == PORT_BASE_CSX0));
    assign csx1_n = !(port_ok && (win == PORT_BASE_CSX1));   // 3'b111 stays unmapped

endmodule

// ==== src/io_port.sv ====
module io_port (
    input  logic                          sclk,
    input  logic                          rst_n,
    input  logic                          port_active,
    input  logic                          ds_n,
    input  logic                          r_w,
    input  logic [sdmac_pkg::PORT_W-1:0]  data_in,
    input  logic [sdmac_pkg::PORT_W-1:0]  pd_in,
    input  logic                          iordy,
    output logic [sdmac_pkg::PORT_W-1:0]  pd_out,
    output logic                          pd_oe,
    output logic                          ior_n,
    output logic                          iow_n,
    output logic                          dsack_n,
    output logic [sdmac_pkg::DATA_W-1:0]  port_data
);
    import sdmac_pkg::*;

    port_state_e             state;                  // Sequencer state
    logic                    rd;                     // Direction of current access
    logic [STROBE_CNT_W-1:0] cnt;                    // Strobe width counter
    logic [PORT_W-1:0]       rd_data;                // Captured peripheral data

    // Write data latched at access start, held through the strobe
    always_ff @(posedge sclk) begin
        if (state == PS_IDLE && port_active && !ds_n && !r_w) begin
            pd_out <= data_in;
        end
    end

    // Read data sampled as the strobe releases
    always_ff @(posedge sclk) begin
        if (state == PS_WAIT && iordy && rd) begin
            rd_data <= pd_in;
        end
    end

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= PS_IDLE;
            rd      <= 1'b1;
            cnt     <= '0;
            ior_n   <= 1'b1;
            iow_n   <= 1'b1;
            pd_oe   <= 1'b0;
            dsack_n <= 1'b1;
        end else begin
            case (state)
                PS_IDLE: begin
                    if (port_active && !ds_n) begin     // Access sampled here
                        rd    <= r_w;
                        cnt   <= '0;
                        state <= PS_STROBE;
                    end
                end
                PS_STROBE: begin
                    if (cnt == '0) begin                // First edge, drop the strobe
                        ior_n <= !rd;
                        iow_n <= rd;
                        pd_oe <= !rd;                   // Drive port only on writes
                    end
                    cnt <= cnt + 1'b1;
                    if (cnt == STROBE_CNT_W'(STROBE_CYCLES - 1)) begin
                        state <= PS_WAIT;
                    end
                end
                PS_WAIT: begin
                    if (iordy) begin                    // Device ready, finish cycle
                        ior_n   <= 1'b1;
                        iow_n   <= 1'b1;
                        dsack_n <= 1'b0;
                        state   <= PS_ACK;
                    end
                end
                PS_ACK: begin
                    dsack_n <= 1'b1;                    // One cycle pulse
                    pd_oe   <= 1'b0;
                    state   <= PS_DONE;
                end
                PS_DONE: begin
                    if (ds_n) begin                     // CPU closed the cycle
                        state <= PS_IDLE;
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    assign port_data = {{(DATA_W - PORT_W){1'b0}}, rd_data};   // Zero extended

endmodule

// ==== src/registers.sv ====
module registers (
    input  logic                          sclk,
    input  logic                          rst_n,
    input  logic                          reg_sel,
    input  logic                          ds_n,
    input  logic                          r_w,
    input  sdmac_pkg::reg_addr_e          addr,
    input  logic [sdmac_pkg::DATA_W-1:0]  data_in,
    input  logic                          inta,
    input  logic                          intb,
    output logic [sdmac_pkg::DATA_W-1:0]  reg_data,
    output logic                          sterm_n,
    output logic                          int_n
);
    import sdmac_pkg::*;

    logic [DAWR_W-1:0]  dawr;                        // Data width scratch
    logic [DATA_W-1:0]  wtc;                         // Word transfer count
    logic [CONTR_W-1:0] contr;                       // Control
    logic [DATA_W-1:0]  acr;                         // Address register
    logic [ISTR_W-1:0]  istr;                        // Interrupt status, derived

    logic pend;                                      // Access sampled, ack next edge
    logic done;                                      // Ack given for this strobe
    logic start;                                     // New access this edge
    logic inta_s;                                    // Synchronised SCSI interrupt
    logic intb_s;                                    // Synchronised spare interrupt

    assign start = reg_sel && !ds_n && !pend && !done;

    // One shot acknowledge
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            pend    <= 1'b0;
            done    <= 1'b0;
            sterm_n <= 1'b1;
        end else begin
            sterm_n <= !pend;                        // Low for exactly one cycle
            if (start) begin
                pend <= 1'b1;
            end else if (pend) begin
                pend <= 1'b0;
                done <= 1'b1;
            end else if (!reg_sel) begin
                done <= 1'b0;                        // Re-arm once as_n has risen
            end
        end
    end

    // Register writes, landing with the acknowledge
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            dawr  <= '0;
            wtc   <= '0;
            contr <= '0;
            acr   <= '0;
        end else if (pend && !r_w) begin
            case (addr)
                REG_DAWR:  dawr  <= data_in[DAWR_W-1:0];
                REG_WTC:   wtc   <= data_in;
                REG_CONTR: contr <= data_in[CONTR_W-1:0];
                REG_ACR:   acr   <= data_in;
                default: ;                           // ISTR and holes ignore writes
            endcase
        end
    end

    // Interrupt inputs, one register stage
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            inta_s <= 1'b0;
            intb_s <= 1'b0;
        end else begin
            inta_s <= inta;
            intb_s <= intb;
        end
    end

    always_comb begin
        istr             = '0;
        istr[ISTR_INTA]  = inta_s;
        istr[ISTR_INTB]  = intb_s;
        istr[ISTR_INT_P] = inta_s || intb_s;         // Either source pending
    end

    // Readback mux, zero extended
    always_comb begin
        reg_data = '0;
        case (addr)
            REG_DAWR:  reg_data[DAWR_W-1:0]  = dawr;
            REG_WTC:   reg_data              = wtc;
            REG_CONTR: reg_data[CONTR_W-1:0] = contr;
            REG_ACR:   reg_data              = acr;
            REG_ISTR:  reg_data[ISTR_W-1:0]  = istr;
            default:   reg_data              = '0;   // Unmapped reads zero
        endcase
    end

    // Only ever pulled low, board side is open collector
    assign int_n = !(contr[CONTR_INTEN] && (inta_s || intb_s));

endmodule

// ==== src/resdmac.sv ====
module resdmac (
    input  logic                          sclk,
    input  logic                          rst_n,
    input  logic                          cs_n,
    input  logic                          as_n,
    input  logic                          ds_n,
    input  logic                          r_w,
    input  logic [6:2]                    addr,
    input  logic                          a12,
    input  logic [sdmac_pkg::DATA_W-1:0]  data_in,
    output logic [sdmac_pkg::DATA_W-1:0]  data_out,
    output logic                          data_oe,
    output logic                          sterm_n,
    output logic                          dsack_n,
    output logic                          int_n,
    input  logic                          inta,
    input  logic                          intb,
    input  logic [sdmac_pkg::PORT_W-1:0]  pd_in,
    input  logic                          iordy,
    output logic [sdmac_pkg::PORT_W-1:0]  pd_out,
    output logic                          pd_oe,
    output logic                          ior_n,
    output logic                          iow_n,
    output logic                          css_n,
    output logic                          csx0_n,
    output logic                          csx1_n,
    output logic                          led_rd_n,
    output logic                          led_wr_n
);
    import sdmac_pkg::*;

    logic              reg_sel;                      // Register space hit
    logic              port_active;                  // Any peripheral selected
    logic              cyc_open;                     // cs_n, as_n and ds_n all low
    logic [DATA_W-1:0] reg_data;                     // Register readback
    logic [DATA_W-1:0] port_data;                    // Peripheral readback

    addr_decoder DECODER (
        .addr    (addr),
        .a12     (a12),
        .cs_n    (cs_n),
        .as_n    (as_n),
        .reg_sel (reg_sel),
        .css_n   (css_n),
        .csx0_n  (csx0_n),
        .csx1_n  (csx1_n)
    );

    assign port_active = !(css_n && csx0_n && csx1_n);

    // 16 bit port for the WD33C93A and spares
    io_port D_PORT (
        .sclk        (sclk),
        .rst_n       (rst_n),
        .port_active (port_active),
        .ds_n        (ds_n),
        .r_w         (r_w),
        .data_in     (data_in[PORT_W-1:0]),
        .pd_in       (pd_in),
        .iordy       (iordy),
        .pd_out      (pd_out),
        .pd_oe       (pd_oe),
        .ior_n       (ior_n),
        .iow_n       (iow_n),
        .dsack_n     (dsack_n),
        .port_data   (port_data)
    );

    registers INT_REG (
        .sclk     (sclk),
        .rst_n    (rst_n),
        .reg_sel  (reg_sel),
        .ds_n     (ds_n),
        .r_w      (r_w),
        .addr     (reg_addr_e'(addr)),
        .data_in  (data_in),
        .inta     (inta),
        .intb     (intb),
        .reg_data (reg_data),
        .sterm_n  (sterm_n),
        .int_n    (int_n)
    );

    assign data_out = port_active ? port_data : reg_data;
    assign data_oe  = !cs_n && !as_n && r_w;         // Drive CPU bus on reads only

    // Activity LEDs, active low
    assign cyc_open = !cs_n && !as_n && !ds_n;
    assign led_rd_n = !(cyc_open && r_w);
    assign led_wr_n = !(cyc_open && !r_w);

endmodule

// ==== sim/resdmac_asserts.sv ====
module resdmac_asserts (
    input logic                   sclk,
    input logic                   rst_n,
    input logic                   cs_n,
    input logic                   data_oe,
    input logic                   sterm_n,
    input logic                   dsack_n,
    input logic                   ior_n,
    input logic                   iow_n,
    input sdmac_pkg::port_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdmac_pkg::*;

    logic strobe_n;                                  // Either port strobe low

    assign strobe_n = ior_n && iow_n;

    // Only one acknowledge source at a time
    ack_exclusive: assert property (@(posedge sclk) disable iff (!rst_n)
        !(!sterm_n && !dsack_n)) else $error("sterm_n and dsack_n low together");

    strobe_exclusive: assert property (@(posedge sclk) disable iff (!rst_n)
        !(!ior_n && !iow_n)) else $error("ior_n and iow_n low together");

    // Minimum strobe width once the strobe drops
    strobe_width: assert property (@(posedge sclk) disable iff (!rst_n)
        $fell(strobe_n) |-> !strobe_n [*STROBE_CYCLES])
        else $error("port strobe shorter than minimum width");

    bus_released: assert property (@(posedge sclk) disable iff (!rst_n)
        cs_n |-> !data_oe) else $error("data_oe high without chip select");

    // Register acknowledge never overlaps a port cycle
    port_idle_on_sterm: assert property (@(posedge sclk) disable iff (!rst_n)
        !sterm_n |-> state == PS_IDLE) else $error("port sequencer busy during sterm_n");

    sterm_one_cycle: assert property (@(posedge sclk) disable iff (!rst_n)
        !sterm_n |=> sterm_n) else $error("sterm_n held longer than one cycle");

endmodule

bind resdmac resdmac_asserts ASSERTS (
    .sclk    (sclk),
    .rst_n   (rst_n),
    .cs_n    (cs_n),
    .data_oe (data_oe),
    .sterm_n (sterm_n),
    .dsack_n (dsack_n),
    .ior_n   (ior_n),
    .iow_n   (iow_n),
    .state   (D_PORT.state)
);

// ==== sim/tb_resdmac.sv ====
module tb_resdmac;
    timeunit 1ns;
    timeprecision 100ps;
    import sdmac_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYC    = 16;
    localparam int MAX_VEC    = 256;
    localparam int ACK_LIMIT  = 64;                  // Cycles before giving up on an ack

    logic              sclk = 1'b0;
    logic              rst_n;
    logic              cs_n, as_n, ds_n, r_w, a12;
    logic [6:2]        addr;
    logic [DATA_W-1:0] data_in, data_out;
    logic              data_oe, sterm_n, dsack_n, int_n;
    logic              inta, intb, iordy;
    logic [PORT_W-1:0] pd_in, pd_out;
    logic              pd_oe, ior_n, iow_n;
    logic              css_n, csx0_n, csx1_n;
    logic              led_rd_n, led_wr_n;

    logic [95:0]       vec_mem [0:MAX_VEC-1];        // One packed access per entry
    logic [PORT_W-1:0] port_mem [0:11];              // Four words per chip select
    int                port_slot;                    // Selected peripheral word, -1 if none
    int                n_vec = 0;

    resdmac UUT (.*);

    always #(CLK_PERIOD / 2) sclk = !sclk;

    // Peripheral model, word picked by select and addr[3:2]
    always_comb begin
        if (!css_n)       port_slot = 0 + int'(addr[3:2]);
        else if (!csx0_n) port_slot = 4 + int'(addr[3:2]);
        else if (!csx1_n) port_slot = 8 + int'(addr[3:2]);
        else              port_slot = -1;
    end

    assign pd_in = (!ior_n && port_slot >= 0) ? port_mem[port_slot] : '0;

    always @(posedge iow_n) begin
        if (rst_n && pd_oe && port_slot >= 0) begin
            port_mem[port_slot] = pd_out;            // Latch on strobe release
        end
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input logic [sdmac_pkg::DATA_W-1:0] exp,
                              input logic [sdmac_pkg::DATA_W-1:0] got, input string name);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %0t %s exp %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_bit(input logic exp, input logic got, input string name);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %0t %s exp %b got %b", $time, name, exp, got));
        end
    endtask

    // exp packed as {csx1_n, csx0_n, css_n}
    task automatic check_sel(input logic [2:0] exp, input logic css, input logic csx0,
                             input logic csx1);
        if ({csx1, csx0, css} !== exp) begin
            stop_on_error($sformatf("mismatch %0t selects exp %b got %b", $time, exp,
                                    {csx1, csx0, css}));
        end
    endtask

    // One bus access, entered and left on a falling edge
    task automatic run_access(input logic [95:0] v, input int num);
        logic [3:0] kind;
        logic       rd;
        logic       is_port;
        int         hold;
        int         cycles;
        int         strobe_cnt;
        kind    = v[95:92];
        rd      = (kind == 4'd0) || (kind == 4'd2);
        is_port = (kind == 4'd2) || (kind == 4'd3);
        hold    = int'($urandom % 6);                // iordy hold-off past minimum strobe
        a12     = v[88];
        addr    = v[84:80];
        data_in = v[79:48];
        inta    = v[44];
        intb    = v[40];
        r_w     = rd;
        iordy   = !is_port;                          // Device busy at port start
        cs_n    = 1'b0;
        as_n    = 1'b0;
        ds_n    = 1'b0;
        @(negedge sclk);
        check_sel(v[2:0], css_n, csx0_n, csx1_n);
        check_bit(!rd, led_rd_n, "led_rd_n");
        check_bit(rd, led_wr_n, "led_wr_n");
        if (kind == 4'd4) begin                      // Unclaimed space, nothing may answer
            repeat (6) begin
                check_bit(1'b1, sterm_n, "sterm_n");
                check_bit(1'b1, dsack_n, "dsack_n");
                check_bit(1'b1, ior_n && iow_n, "port_strobe_n");
                @(negedge sclk);
            end
        end else begin
            cycles     = 0;
            strobe_cnt = 0;
            while (sterm_n && dsack_n) begin
                if (!ior_n || !iow_n) begin          // Count strobe width at the pins
                    strobe_cnt++;
                    check_bit(!rd, ior_n, "ior_n");
                    check_bit(rd, iow_n, "iow_n");
                    check_bit(!rd, pd_oe, "pd_oe");
                end
                if (is_port && strobe_cnt >= STROBE_CYCLES + hold) begin
                    iordy = 1'b1;
                end
                cycles++;
                if (cycles > ACK_LIMIT) begin
                    stop_on_error($sformatf("no acknowledge for access %0d", num));
                end
                @(negedge sclk);
            end
            if (is_port) begin
                check_bit(1'b1, sterm_n, "sterm_n");
                if (strobe_cnt < STROBE_CYCLES) begin
                    stop_on_error("dsack_n came before the minimum strobe width");
                end
                check_data(DATA_W'(STROBE_CYCLES + hold), DATA_W'(strobe_cnt), "strobe_width");
            end else begin
                check_bit(1'b1, dsack_n, "dsack_n");
            end
            check_bit(rd, data_oe, "data_oe");
            if (rd) begin
                check_data(v[39:8], data_out, "data_out");
            end
            check_bit(v[4], int_n, "int_n");
        end
        cs_n  = 1'b1;                                // Close the cycle
        as_n  = 1'b1;
        ds_n  = 1'b1;
        iordy = 1'b1;
    endtask

    initial begin
        int unsigned seed;
        int unsigned dummy;
        seed    = 69;
        dummy   = $urandom(seed);
        rst_n   = 1'b0;
        cs_n    = 1'b1;
        as_n    = 1'b1;
        ds_n    = 1'b1;
        r_w     = 1'b1;
        a12     = 1'b0;
        addr    = '0;
        data_in = '0;
        inta    = 1'b0;
        intb    = 1'b0;
        iordy   = 1'b1;
        for (int i = 0; i < 12; i++) begin
            port_mem[i] = 16'h5A00 ^ PORT_W'(i * 16'h0123);   // Unique per word
        end
        for (int i = 0; i < MAX_VEC; i++) begin
            vec_mem[i] = '1;                         // Kind F marks the end
        end
        $readmemh("sim/resdmac_vectors.txt", vec_mem);
        while (n_vec < MAX_VEC && vec_mem[n_vec][95:92] != 4'hF) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            stop_on_error("vector file empty or missing");
        end
        repeat (RST_CYC) @(posedge sclk);
        @(negedge sclk);
        rst_n = 1'b1;
        @(negedge sclk);
        check_bit(1'b1, sterm_n, "sterm_n");         // Idle bus after reset
        check_bit(1'b1, dsack_n, "dsack_n");
        check_bit(1'b1, int_n, "int_n");
        check_bit(1'b1, ior_n, "ior_n");
        check_bit(1'b1, iow_n, "iow_n");
        check_bit(1'b0, pd_oe, "pd_oe");
        check_bit(1'b0, data_oe, "data_oe");
        check_bit(1'b1, led_rd_n, "led_rd_n");
        check_bit(1'b1, led_wr_n, "led_wr_n");
        for (int i = 0; i < n_vec; i++) begin
            run_access(vec_mem[i], i);
            repeat (2 + ($urandom % 4)) @(negedge sclk);   // Port needs two idle edges
        end
        $display("sim passed");
        $finish;
    end

    // Watchdog sized from the vector count, armed once reset is released
    initial begin
        wait (rst_n === 1'b1);
        #((n_vec * 40 + RST_CYC) * CLK_PERIOD);
        stop_on_error("watchdog expired before the vectors were done");
    end

endmodule

// ==== resdmac.f ====
src/sdmac_pkg.sv
src/addr_decoder.sv
src/io_port.sv
src/registers.sv
src/resdmac.sv
sim/resdmac_asserts.sv
sim/tb_resdmac.sv

// ==== sim/resdmac_vectors.txt ====
// kind_a12_addr_wdata_inta_intb_rdata_intn_sel, kind 0 rd 1 wr 2 port rd 3 port wr 4 no ack
// addr is the word address addr[6:2], sel is {csx1_n,csx0_n,css_n}
0_0_00_00000000_0_0_00000000_1_7
0_0_01_00000000_0_0_00000000_1_7
0_0_02_00000000_0_0_00000000_1_7
0_0_03_00000000_0_0_00000000_1_7
0_0_07_00000000_0_0_00000000_1_7
1_0_01_DEADBEEF_0_0_00000000_1_7
0_0_01_00000000_0_0_DEADBEEF_1_7
1_0_03_12345678_0_0_00000000_1_7
0_0_03_00000000_0_0_12345678_1_7
1_0_00_FFFFFFFF_0_0_00000000_1_7
0_0_00_00000000_0_0_0000000F_1_7
1_0_02_FFFFFFFB_0_0_00000000_1_7
0_0_02_00000000_0_0_000000FB_1_7
1_0_05_CAFEF00D_0_0_00000000_1_7
0_0_05_00000000_0_0_00000000_1_7
1_0_07_FFFFFFFF_0_0_00000000_1_7
0_0_07_00000000_0_0_00000000_1_7
0_0_07_00000000_1_0_00000018_1_7
1_0_02_00000004_1_0_00000000_0_7
0_0_07_00000000_1_1_0000001C_0_7
0_0_07_00000000_0_1_00000014_0_7
0_0_07_00000000_0_0_00000000_1_7
1_1_03_00000055_0_0_00000000_1_7
0_1_03_00000000_0_0_00000055_1_7
1_0_02_00000000_0_1_00000000_1_7
0_0_02_00000000_0_1_00000000_1_7
3_0_10_0000ABCD_0_0_00000000_1_6
2_0_10_00000000_0_0_0000ABCD_1_6
3_0_15_FFFF1234_0_0_00000000_1_5
2_0_15_00000000_0_0_00001234_1_5
3_0_1A_00005678_0_0_00000000_1_3
2_0_1A_00000000_0_0_00005678_1_3
2_0_10_00000000_0_0_0000ABCD_1_6
3_0_13_0000BEEF_0_0_00000000_1_6
2_0_13_00000000_0_0_0000BEEF_1_6
4_1_10_00000000_0_0_00000000_1_7
4_1_18_00000000_0_0_00000000_1_7
2_0_1A_00000000_0_0_00005678_1_3
